// ==== vlog.f ====
hw/na_regmap_pkg.sv
hw/na_conf_pkg.sv
hw/na_ctlist.sv
hw/na_conf_regs.sv
hw/na_bus_slave.sv
hw/na_conf_top.sv
dv/na_conf_checker.sv
dv/tb_na_conf.sv

// ==== Makefile ====
# Verilator build of the configuration window testbench.
TOP := tb_na_conf

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): vlog.f hw/*.sv dv/*.sv
	verilator --binary --timing --timescale 1ns/10ps -f vlog.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

lint:
	verilator --lint-only --timing --timescale 1ns/10ps -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== dv/tb_na_conf.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench of the configuration window. Runs random four-phase accesses
// against the DUT while the checker compares every response.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_na_conf
  import na_regmap_pkg::*;
();

  localparam int NUM_ACCESSES = 600;
  localparam int RESET_CYCLES = 8;
  // Worst case per access is 3 handshake cycles, 3 hold cycles and 1 gap.
  localparam int CYCLES_PER_ACCESS = 8;
  localparam int TIMEOUT_CYCLES = NUM_ACCESSES * CYCLES_PER_ACCESS + RESET_CYCLES + 200;

  // Offsets with a meaning in the map.
  localparam reg_idx_t DEFINED_OFFSETS [13] = '{
    REG_TILEID, REG_NUMTILES, REG_CONF, REG_COREBASE, REG_DOMAIN_NUMCORES,
    REG_GMEM_SIZE, REG_GMEM_TILE, REG_LMEM_SIZE, REG_NUMCTS, REG_SEED,
    REG_CDC, REG_CDC_DYN, REG_CDC_CONF
  };

  logic       clk;
  logic       rst;
  logic       req;
  addr_t      adr;
  logic       we;
  word_t      wdata;
  logic       ack;
  word_t      rdata;
  logic       err;
  logic [2:0] cdc_conf;
  logic       cdc_enable;
  int         data_errors;
  int         proto_errors;
  int         responses;
  int         cycle_count = 0;

  na_conf_top DUT (
    .clk(clk), .rst(rst), .req(req), .adr(adr), .we(we), .wdata(wdata),
    .ack(ack), .rdata(rdata), .err(err), .cdc_conf(cdc_conf), .cdc_enable(cdc_enable)
  );

  na_conf_checker u_checker (
    .clk(clk), .rst(rst), .req(req), .adr(adr), .we(we), .wdata(wdata),
    .ack(ack), .rdata(rdata), .err(err), .cdc_conf(cdc_conf), .cdc_enable(cdc_enable),
    .data_errors(data_errors), .proto_errors(proto_errors), .responses(responses)
  );

  always #5 clk = ~clk;

  // Stops a run whose handshake has stalled.
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  function automatic logic is_defined(reg_idx_t idx);
    foreach (DEFINED_OFFSETS[i]) begin
      if (DEFINED_OFFSETS[i] == idx) return 1'b1;
    end
    return 1'b0;
  endfunction

  // Chooses the next access with the weights of the test mix.
  task automatic pick_access(output addr_t a, output logic w, output word_t d);
    int         roll;
    int         kind;
    logic [3:0] pick;
    reg_idx_t   idx;
    roll = $urandom_range(0, 99);
    kind = $urandom_range(0, 2);
    pick = 4'($urandom_range(0, 12));
    d    = $urandom();
    w    = 1'b0;
    idx  = DEFINED_OFFSETS[pick];
    if (roll >= 90 && kind == 0) begin
      // A hole or an unused offset below the list window.
      do begin
        idx = 10'($urandom_range(0, 127));
      end while (is_defined(idx));
    end else if (roll >= 90 && kind == 2) begin
      // A write that must be dropped by a read-only register.
      while (idx == REG_CDC_CONF) begin
        idx = DEFINED_OFFSETS[4'($urandom_range(0, 12))];
      end
      w = 1'b1;
    end
    a = addr_t'({idx, 2'b00});
    if (roll >= 60 && roll < 80) begin
      a = 16'h0200 | addr_t'($urandom_range(0, 511));
    end else if (roll >= 80 && roll < 90) begin
      a = addr_t'({REG_CDC_CONF, 2'b00});
      w = 1'b1;
    end else if (roll >= 90 && kind == 1) begin
      a = addr_t'($urandom_range(32'h1000, 32'hffff));
      w = 1'($urandom_range(0, 1));
    end
  endtask

  // One four-phase access. Entered and left 1 ns after a rising edge.
  task automatic bus_access(input addr_t a, input logic w, input word_t d);
    int hold;
    hold  = $urandom_range(0, 3);
    req   = 1'b1;
    adr   = a;
    we    = w;
    wdata = d;
    do begin
      @(posedge clk);
      #1;
    end while (ack !== 1'b1);
    repeat (hold) begin
      @(posedge clk);
      #1;
    end
    req = 1'b0;
    do begin
      @(posedge clk);
      #1;
    end while (ack !== 1'b0);
  endtask

  initial begin
    int    seed_value;
    int    gap;
    addr_t a;
    logic  w;
    word_t d;
    seed_value = $urandom(32'h8f4d_46d6);
    clk   = 1'b0;
    rst   = 1'b1;
    req   = 1'b0;
    adr   = '0;
    we    = 1'b0;
    wdata = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int n = 0; n < NUM_ACCESSES; n++) begin
      pick_access(a, w, d);
      bus_access(a, w, d);
      gap = $urandom_range(0, 1);
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
    end
    repeat (4) @(posedge clk);
    $display("Errors: %0d data, %0d handshake; %0d of %0d responses checked (seed %0d)",
             data_errors, proto_errors, responses, NUM_ACCESSES, seed_value);
    if (data_errors == 0 && proto_errors == 0 && responses == NUM_ACCESSES) begin
      $display("Simulation finished: PASS");
    end else begin
      if (responses != NUM_ACCESSES) begin
        $display("The number of responses does not match the number of accesses");
      end
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/na_conf_checker.sv ====
////////////////////////////////////////////////////////////////////////////
// Response checker of the configuration window. Models the register map,
// the seed LFSR and the CDC setting, and follows the req/ack handshake.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module na_conf_checker
  import na_regmap_pkg::*;
  import na_conf_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       req,
  input  addr_t      adr,
  input  logic       we,
  input  word_t      wdata,
  input  logic       ack,
  input  word_t      rdata,
  input  logic       err,
  input  logic [2:0] cdc_conf,
  input  logic       cdc_enable,
  output int         data_errors,
  output int         proto_errors,
  output int         responses
);

  // Model of the seed and the CDC setting as software should see them.
  word_t      seed_model;
  logic [2:0] cdc_model;

  // The request the master is waiting on, and the handshake history.
  addr_t      req_adr;
  logic       req_we;
  word_t      req_wdata;
  int         wait_count;
  logic       prev_req;
  logic       prev_ack;
  logic       cdc_write;

  initial begin
    data_errors  = 0;
    proto_errors = 0;
    responses    = 0;
  end

  // Expected read data of an address inside the window.
  function automatic word_t model_read(addr_t a);
    logic [5:0] pos;
    int         k;
    ct_id_t     entry;
    k = int'(a[6:1]);
    if (a[11:9] == CTLIST_REGION) begin
      // Software sees the list back to front. Past the count it reads zero.
      entry = '0;
      if (k < int'(NUM_CTS)) begin
        pos   = 6'(int'(NUM_CTS) - 1 - k);
        entry = CT_LIST[pos];
      end
      return a[1] ? word_t'(entry) : (word_t'(entry) << 16);
    end
    case (a[11:2])
      REG_TILEID:          return TILE_ID;
      REG_NUMTILES:        return NUM_TILES;
      REG_CONF:            return (word_t'(NA_ENABLE_MPSIMPLE) << REGBIT_CONF_MPSIMPLE) |
                                  (word_t'(NA_ENABLE_DMA) << REGBIT_CONF_DMA);
      REG_COREBASE:        return CORE_BASE;
      REG_DOMAIN_NUMCORES: return CORES_PER_TILE;
      REG_GMEM_SIZE:       return GMEM_SIZE;
      REG_GMEM_TILE:       return GMEM_TILE;
      REG_LMEM_SIZE:       return LMEM_SIZE;
      REG_NUMCTS:          return word_t'(NUM_CTS);
      REG_SEED:            return seed_model;
      REG_CDC:             return word_t'(CDC_PRESENT);
      REG_CDC_DYN:         return word_t'(CDC_DYNAMIC);
      REG_CDC_CONF:        return word_t'(cdc_model);
      default:             return '0;
    endcase
  endfunction

  // One step of the seed. A one that drops out of the low end folds the taps in.
  function automatic word_t lfsr_step(word_t s);
    if (s[0]) begin
      return (s >> 1) ^ SEED_TAPS;
    end
    return s >> 1;
  endfunction

  task automatic check_value(string test, word_t expected, word_t actual);
    if (actual !== expected) begin
      data_errors++;
      $display("[FAIL] %s: expected 0x%08h, actual 0x%08h at %0t",
               test, expected, actual, $time);
    end
  endtask

  task automatic report_break(string what);
    proto_errors++;
    $display("Handshake error at %0t: %s", $time, what);
  endtask

  // Compares one response with the model, then applies its side effects.
  task automatic check_response();
    word_t expected;
    responses++;
    if (req_adr[15:12] != 4'h0) begin
      // Out of the window, nothing may change.
      check_value("region_err", 32'd1, word_t'(err));
      check_value("region_rdata", '0, rdata);
    end else if (req_we) begin
      check_value("write_err", '0, word_t'(err));
      if (req_adr[11:2] == REG_CDC_CONF) begin
        cdc_model = req_wdata[2:0];
        cdc_write = 1'b1;
      end
    end else begin
      check_value("read_err", '0, word_t'(err));
      expected = model_read(req_adr);
      if (req_adr[11:9] == CTLIST_REGION) begin
        check_value("list_read", expected, rdata);
      end else if (req_adr[11:2] == REG_SEED) begin
        check_value("seed_read", expected, rdata);
        seed_model = lfsr_step(seed_model);
      end else begin
        check_value("scalar_read", expected, rdata);
      end
    end
  endtask

  // The master only moves on the rising edge, so the falling edge sees
  // settled values, and the previous sample is what the slave last saw.
  always @(negedge clk) begin
    if (rst) begin
      if (ack !== 1'b0 || cdc_enable !== 1'b0) begin
        report_break("ack or cdc_enable is not low during reset");
      end
      check_value("cdc_conf_reset", word_t'(CDC_CONF_DEFAULT), word_t'(cdc_conf));
      seed_model = SEED_INIT;
      cdc_model  = CDC_CONF_DEFAULT;
      wait_count = 0;
    end else begin
      cdc_write = 1'b0;
      if (req && !ack) begin
        req_adr   = adr;
        req_we    = we;
        req_wdata = wdata;
        wait_count++;
      end
      if (ack && !prev_ack) begin
        if (wait_count == 0) begin
          report_break("ack rose with no request pending");
        end else begin
          // Two sampled edges of req come before the edge that raises ack.
          check_value("ack_latency", 32'd2, word_t'(wait_count));
          check_response();
        end
        wait_count = 0;
      end
      if (!ack && prev_ack && prev_req) begin
        report_break("ack fell while req was still high");
      end
      if (ack && prev_ack && !prev_req) begin
        report_break("ack stayed high after req was released");
      end
      // A pulse belongs only to the cycle in which a CDC write completes.
      check_value("cdc_enable", word_t'(cdc_write), word_t'(cdc_enable));
      check_value("cdc_conf", word_t'(cdc_model), word_t'(cdc_conf));
    end
    prev_req = req;
    prev_ack = ack;
  end

endmodule

`default_nettype wire

// ==== hw/na_conf_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Configuration window of the tile network adapter. Connects the bus
// slave to the scalar register block and the compute-tile list lookup.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module na_conf_top
  import na_regmap_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       req,
  input  addr_t      adr,
  input  logic       we,
  input  word_t      wdata,
  output logic       ack,
  output word_t      rdata,
  output logic       err,
  output logic [2:0] cdc_conf,
  output logic       cdc_enable
);

  // Single-cycle access strobes from the slave.
  logic  rd_stb;
  logic  wr_stb;

  // Read data returned by the two side blocks.
  word_t reg_rdata;
  word_t ct_rdata;

  // The slave runs the handshake and picks one of the two read paths.
  na_bus_slave u_slave (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .adr       (adr),
    .we        (we),
    .wdata     (wdata),
    .ack       (ack),
    .rdata     (rdata),
    .err       (err),
    .rd_stb    (rd_stb),
    .wr_stb    (wr_stb),
    .reg_rdata (reg_rdata),
    .ct_rdata  (ct_rdata)
  );

  // Scalar registers, seed and CDC setting.
  na_conf_regs u_regs (
    .clk        (clk),
    .rst        (rst),
    .adr        (adr),
    .rd_stb     (rd_stb),
    .wr_stb     (wr_stb),
    .wdata      (wdata),
    .reg_rdata  (reg_rdata),
    .cdc_conf   (cdc_conf),
    .cdc_enable (cdc_enable)
  );

  // Compute-tile list, decoded straight from the address.
  na_ctlist u_ctlist (
    .adr      (adr),
    .ct_rdata (ct_rdata)
  );

endmodule

`default_nettype wire

// ==== hw/na_bus_slave.sv ====
////////////////////////////////////////////////////////////////////////////
// Four-phase req/ack slave of the configuration window. Checks the region,
// strobes the register block, selects the read data and flags errors.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module na_bus_slave
  import na_regmap_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  req,
  input  addr_t adr,
  input  logic  we,
  input  word_t wdata,
  output logic  ack,
  output word_t rdata,
  output logic  err,
  output logic  rd_stb,
  output logic  wr_stb,
  input  word_t reg_rdata,
  input  word_t ct_rdata
);

  // IDLE waits for req, ACCESS is the single strobe cycle and RESP holds
  // ack until the master lets go of req.
  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    RESP
  } state_t;

  state_t state;

  // The window only covers the lowest 4 KiB.
  logic  adr_valid;

  // Read data of the addressed side block.
  word_t sel_rdata;

  assign adr_valid = (adr[15:12] == 4'h0);

  // The list window at byte 0x200 comes from the lookup, everything else
  // in the valid range from the scalar registers.
  assign sel_rdata = (adr[11:9] == CTLIST_REGION) ? ct_rdata : reg_rdata;

  // Strobes are high for the one ACCESS cycle. An invalid address never
  // reaches the register block, so it cannot step the seed or touch CDC.
  assign rd_stb = (state == ACCESS) && adr_valid && !we;
  assign wr_stb = (state == ACCESS) && adr_valid && we;

  // Handshake control. The master holds adr, we and wdata stable while
  // req is high, so the address seen in ACCESS is the requested one.
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      ack   <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (req) begin
            state <= ACCESS;
          end
        end
        ACCESS: begin
          state <= RESP;
          ack   <= 1'b1;
        end
        RESP: begin
          // Stay here as long as the master needs; no new access starts.
          if (!req) begin
            state <= IDLE;
            ack   <= 1'b0;
          end
        end
        default: begin
          state <= IDLE;
          ack   <= 1'b0;
        end
      endcase
    end
  end

  // Response payload. It is loaded on the edge that raises ack and then
  // stays put for the whole RESP phase.
  always_ff @(posedge clk) begin
    if (state == ACCESS) begin
      rdata <= adr_valid ? sel_rdata : '0;
      err   <= !adr_valid;
    end
  end

endmodule

`default_nettype wire

// ==== hw/na_conf_regs.sv ====
////////////////////////////////////////////////////////////////////////////
// Scalar configuration registers. Decodes the word offset into the fixed
// system facts, runs the seed LFSR and holds the writable CDC setting.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module na_conf_regs
  import na_regmap_pkg::*;
  import na_conf_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  addr_t      adr,
  input  logic       rd_stb,
  input  logic       wr_stb,
  input  word_t      wdata,
  output word_t      reg_rdata,
  output logic [2:0] cdc_conf,
  output logic       cdc_enable
);

  // Word offset of the current access.
  reg_idx_t idx;

  // Current seed and the value after one LFSR step.
  word_t seed;
  word_t seed_next;

  assign idx = adr[11:2];

  // Galois LFSR step. The word shifts right by one bit, and the taps are
  // folded in whenever a one drops out of the low end.
  assign seed_next = {1'b0, seed[31:1]} ^ (seed[0] ? SEED_TAPS : '0);

  // Read decode. This is purely combinational from the address so that
  // the bus slave can capture it on the edge that ends its access cycle.
  always_comb begin
    reg_rdata = '0;
    case (idx)
      REG_TILEID:          reg_rdata = TILE_ID;
      REG_NUMTILES:        reg_rdata = NUM_TILES;
      REG_CONF: begin
        // Only the two feature bits are defined, the rest reads zero.
        reg_rdata[REGBIT_CONF_MPSIMPLE] = NA_ENABLE_MPSIMPLE;
        reg_rdata[REGBIT_CONF_DMA]      = NA_ENABLE_DMA;
      end
      REG_COREBASE:        reg_rdata = CORE_BASE;
      REG_DOMAIN_NUMCORES: reg_rdata = CORES_PER_TILE;
      REG_GMEM_SIZE:       reg_rdata = GMEM_SIZE;
      REG_GMEM_TILE:       reg_rdata = GMEM_TILE;
      REG_LMEM_SIZE:       reg_rdata = LMEM_SIZE;
      REG_NUMCTS:          reg_rdata = word_t'(NUM_CTS);
      REG_SEED:            reg_rdata = seed;
      REG_CDC:             reg_rdata = word_t'(CDC_PRESENT);
      REG_CDC_DYN:         reg_rdata = word_t'(CDC_DYNAMIC);
      REG_CDC_CONF:        reg_rdata = word_t'(cdc_conf);
      // Holes and unassigned offsets read as zero.
      default:             reg_rdata = '0;
    endcase
  end

  // The seed advances once per read of REG_SEED. The read data has been
  // taken from the old value on the same edge, so software sees SEED_INIT
  // first and then each successive step.
  always_ff @(posedge clk) begin
    if (rst) begin
      seed <= SEED_INIT;
    end else if (rd_stb && (idx == REG_SEED)) begin
      seed <= seed_next;
    end
  end

  // The CDC setting is the only writable register. A write loads the low
  // three data bits and raises cdc_enable for one cycle so the clock logic
  // picks up the new value. Writes to any other offset are dropped.
  always_ff @(posedge clk) begin
    if (rst) begin
      cdc_conf   <= CDC_CONF_DEFAULT;
      cdc_enable <= 1'b0;
    end else begin
      cdc_enable <= 1'b0;
      if (wr_stb && (idx == REG_CDC_CONF)) begin
        cdc_conf   <= wdata[2:0];
        cdc_enable <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/na_ctlist.sv ====
////////////////////////////////////////////////////////////////////////////
// Compute-tile list lookup. Places one 16-bit list entry into the half of
// a 32-bit word that address bit 1 selects.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module na_ctlist
  import na_regmap_pkg::*;
  import na_conf_pkg::*;
(
  input  addr_t adr,
  output word_t ct_rdata
);

  // The list as software sees it, with the order of CT_LIST reversed.
  ct_id_t rev_list [64];

  // Halfword index inside the list window.
  logic [5:0] k;

  // The entry selected by the current address.
  ct_id_t entry;

  assign k = adr[6:1];

  // Build the reversed table at elaboration time. Index k maps to entry
  // NUM_CTS-1-k of the package list, and indices past the end are zero.
  for (genvar i = 0; i < 64; i++) begin : g_rev
    if (i < NUM_CTS) begin : g_used
      assign rev_list[i] = CT_LIST[NUM_CTS - 1 - i];
    end else begin : g_unused
      assign rev_list[i] = '0;
    end
  end

  assign entry = rev_list[k];

  // Two entries share one word. The even halfword sits in the upper half
  // and the odd halfword in the lower half; the other half reads zero.
  always_comb begin
    if (adr[1]) begin
      ct_rdata = {16'h0000, entry};
    end else begin
      ct_rdata = {entry, 16'h0000};
    end
  end

endmodule

`default_nettype wire

// ==== hw/na_conf_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// System configuration that this tile reports to software. The values
// describe an eight tile system with one memory tile and one I/O tile.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package na_conf_pkg;

  import na_regmap_pkg::*;

  // Position of this tile and the size of the system.
  localparam word_t TILE_ID   = 32'd2;
  localparam word_t NUM_TILES = 32'd8;

  // Each tile carries two cores, so this tile starts at core 4.
  localparam word_t CORES_PER_TILE = 32'd2;
  localparam word_t CORE_BASE      = 32'd4;

  // Global memory lives in tile 3; local memory is per tile.
  localparam word_t GMEM_SIZE = 32'h0100_0000;
  localparam word_t GMEM_TILE = 32'd3;
  localparam word_t LMEM_SIZE = 32'h0000_8000;

  // Number of compute tiles. The list below never holds more than 64.
  localparam int unsigned NUM_CTS = 6;

  // Tiles 3 and 7 are not compute tiles, so they are missing here.
  // Entries past NUM_CTS are zero.
  localparam ct_id_t CT_LIST [64] = '{
    0:       16'd0,
    1:       16'd1,
    2:       16'd2,
    3:       16'd4,
    4:       16'd5,
    5:       16'd6,
    default: 16'd0
  };

  // Network adapter features built into this tile.
  localparam logic NA_ENABLE_MPSIMPLE = 1'b1;
  localparam logic NA_ENABLE_DMA      = 1'b1;

  // Clock-domain-crossing capabilities and the reset setting.
  localparam logic       CDC_PRESENT      = 1'b1;
  localparam logic       CDC_DYNAMIC      = 1'b1;
  localparam logic [2:0] CDC_CONF_DEFAULT = 3'd1;

  // Start value of the seed LFSR. It must not be zero.
  localparam word_t SEED_INIT = 32'hace1_2468;

endpackage

`default_nettype wire

// ==== hw/na_regmap_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Register map of the network adapter configuration window. Holds the
// word offsets, the feature bit positions, the address regions and the
// width types that the bus, the registers and the list share.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package na_regmap_pkg;

  // A data word as it travels on the bus and out of every register.
  typedef logic [31:0] word_t;

  // A byte address into the configuration window.
  typedef logic [15:0] addr_t;

  // A word offset, taken from address bits 11 to 2.
  typedef logic [9:0] reg_idx_t;

  // The id of one compute tile as it is stored in the list.
  typedef logic [15:0] ct_id_t;

  // Word offsets of the scalar registers.
  // Offsets 2 and 5 are holes and read as zero.
  localparam reg_idx_t REG_TILEID          = 10'd0;
  localparam reg_idx_t REG_NUMTILES        = 10'd1;
  localparam reg_idx_t REG_CONF            = 10'd3;
  localparam reg_idx_t REG_COREBASE        = 10'd4;
  localparam reg_idx_t REG_DOMAIN_NUMCORES = 10'd6;
  localparam reg_idx_t REG_GMEM_SIZE       = 10'd7;
  localparam reg_idx_t REG_GMEM_TILE       = 10'd8;
  localparam reg_idx_t REG_LMEM_SIZE       = 10'd9;
  localparam reg_idx_t REG_NUMCTS          = 10'd10;
  localparam reg_idx_t REG_SEED            = 10'd11;

  // The clock-domain-crossing group starts at byte 0x100.
  localparam reg_idx_t REG_CDC             = 10'd64;
  localparam reg_idx_t REG_CDC_DYN         = 10'd65;
  localparam reg_idx_t REG_CDC_CONF        = 10'd66;

  // Bit positions of the feature flags in the REG_CONF word.
  localparam int REGBIT_CONF_MPSIMPLE = 0;
  localparam int REGBIT_CONF_DMA      = 1;

  // Address bits 11 to 9 select the compute-tile list at byte 0x200.
  localparam logic [2:0] CTLIST_REGION = 3'b001;

  // Feedback mask of the Galois LFSR behind the seed register.
  localparam word_t SEED_TAPS = 32'h8020_0003;

endpackage

`default_nettype wire
